// File: design/dma_macros.svh
////////////////////
// AXI4 write DMA widths and encodings
// Bus widths, burst codes and the constant address channel attributes
////////////////////
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

////////////////////
// Widths
`define DMA_ADDR_W 32                 // Byte address
`define DMA_DATA_W 64                 // One beat
`define DMA_LEN_W  8                  // AXI4 awlen
`define DMA_STRB_W 8                  // One strobe per byte lane

////////////////////
// Address channel attributes
`define AXI_SIZE_8B       3'b011      // 8 bytes per beat
`define AXI_BURST_INCR    2'b01
`define AXI_CACHE_DEFAULT 4'b1111     // Bufferable, modifiable, read and write allocate
`define AXI_PROT_DEFAULT  3'b010      // Unprivileged, non-secure, data access

////////////////////
// Write response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_EXOKAY 2'b01
`define AXI_RESP_SLVERR 2'b10
`define AXI_RESP_DECERR 2'b11

`endif

// File: design/dma_pkg.sv
////////////////////
// Shared types of the AXI4 write DMA
// Client command, AXI write channel payloads and FSM state encodings
////////////////////
`include "dma_macros.svh"

package dma_pkg;

   ////////////////////
   // Client side

   // One write command from the client
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;       // Start byte address, 8-byte aligned
      logic [`DMA_LEN_W-1:0]  len;        // Beat count minus one
   } dma_cmd_t;

   ////////////////////
   // AXI side

   // Write address channel payload
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_LEN_W-1:0]  len;
      logic [2:0]             size;
      logic [1:0]             burst;
      logic [3:0]             cache;
      logic [2:0]             prot;
      logic                   lock;       // Normal access only
      logic [3:0]             qos;
   } axi_aw_t;

   // Write data channel payload
   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic [`DMA_STRB_W-1:0] strb;
      logic                   last;       // Final beat of the burst
   } axi_w_t;

   typedef logic [1:0] axi_resp_t;        // bresp code

   ////////////////////
   // FSM states

   // Address / response FSM
   typedef enum logic [1:0] {AW_IDLE, WAIT_AWREADY, WAIT_BVALID, AW_ERROR} aw_state_t;

   // Data beat FSM
   typedef enum logic [1:0] {DW_IDLE, DW_RUN, DW_LAST} dw_state_t;

endpackage

// File: design/dma_write_addr.sv
////////////////////
// AXI4 write DMA command and response controller
// Accepts a client command, drives the write address channel, waits for bresp
////////////////////
`timescale 1ns/1ns
`include "dma_macros.svh"

module dma_write_addr (
   input  logic                  aclk,
   input  logic                  areset,
   // Client command channel
   input  dma_pkg::dma_cmd_t     cmd,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   // AXI write address channel
   output dma_pkg::axi_aw_t      aw,
   output logic                  awvalid,
   input  logic                  awready,
   // AXI write response channel
   input  logic                  bvalid,
   input  dma_pkg::axi_resp_t    bresp,
   output logic                  bready,
   // Burst handoff to the data sequencer
   output logic                  burst_start,
   output logic [`DMA_LEN_W-1:0] burst_len,
   // Status
   output logic                  write_error,
   output dma_pkg::axi_resp_t    error_resp
);

   dma_pkg::aw_state_t state;
   logic               cmd_fire;          // Command handshake this cycle
   logic               resp_good;         // bresp is OKAY or EXOKAY

   assign cmd_fire  = cmd_valid && cmd_ready;
   assign resp_good = (bresp == `AXI_RESP_OKAY) || (bresp == `AXI_RESP_EXOKAY);

   // Data sequencer opens its burst one cycle after this pulse
   assign burst_start = cmd_fire;
   assign burst_len   = cmd.len;

   assign write_error = (state == dma_pkg::AW_ERROR);     // Sticky until reset

   ////////////////////
   // Address and response FSM
   always_ff @(posedge aclk) begin
      if (areset) begin
         state      <= dma_pkg::AW_IDLE;
         cmd_ready  <= 1'b0;
         awvalid    <= 1'b0;
         bready     <= 1'b0;
         error_resp <= `AXI_RESP_OKAY;
      end else begin
         case (state)
            // Offer readiness, then take one command
            dma_pkg::AW_IDLE: begin
               cmd_ready <= 1'b1;
               bready    <= 1'b0;
               if (cmd_fire) begin
                  cmd_ready <= 1'b0;              // One burst in flight
                  awvalid   <= 1'b1;              // Payload loads in parallel
                  state     <= dma_pkg::WAIT_AWREADY;
               end
            end

            // Hold awvalid and the payload until the slave takes them
            dma_pkg::WAIT_AWREADY: begin
               if (awready) begin
                  awvalid <= 1'b0;
                  bready  <= 1'b1;
                  state   <= dma_pkg::WAIT_BVALID;
               end
            end

            // Response decides between the next command and the error state
            dma_pkg::WAIT_BVALID: begin
               if (bvalid) begin
                  bready <= 1'b0;
                  if (resp_good) begin
                     cmd_ready <= 1'b1;           // Ready again next cycle
                     state     <= dma_pkg::AW_IDLE;
                  end else begin
                     error_resp <= bresp;         // Keep SLVERR or DECERR visible
                     state      <= dma_pkg::AW_ERROR;
                  end
               end
            end

            // Parked, only reset leaves this state
            dma_pkg::AW_ERROR: begin
               cmd_ready <= 1'b0;
               awvalid   <= 1'b0;
               bready    <= 1'b0;
            end

            default: state <= dma_pkg::AW_IDLE;
         endcase
      end
   end

   ////////////////////
   // Address payload, stable while awvalid waits
   always_ff @(posedge aclk) begin
      if (cmd_fire) begin
         aw.addr  <= cmd.addr;
         aw.len   <= cmd.len;
         aw.size  <= `AXI_SIZE_8B;           // Full 64-bit beats
         aw.burst <= `AXI_BURST_INCR;
         aw.cache <= `AXI_CACHE_DEFAULT;
         aw.prot  <= `AXI_PROT_DEFAULT;
         aw.lock  <= 1'b0;                   // Normal access
         aw.qos   <= 4'h0;
      end
   end

endmodule

// File: design/dma_write_data.sv
////////////////////
// AXI4 write DMA data beat sequencer
// Passes client beats to the W channel for one burst and marks the last beat
////////////////////
`timescale 1ns/1ns
`include "dma_macros.svh"

module dma_write_data (
   input  logic                   aclk,
   input  logic                   areset,
   // Burst handoff from the address controller
   input  logic                   burst_start,
   input  logic [`DMA_LEN_W-1:0]  burst_len,
   // Client data channel
   input  logic [`DMA_DATA_W-1:0] wr_data,
   input  logic                   wr_data_valid,
   output logic                   wr_data_ready,
   // AXI write data channel
   output dma_pkg::axi_w_t        w,
   output logic                   wvalid,
   input  logic                   wready
);

   dma_pkg::dw_state_t    state;
   logic [`DMA_LEN_W-1:0] beat_cnt;       // Beats moved in this burst
   logic [`DMA_LEN_W-1:0] len_q;          // awlen of the open burst
   logic                  burst_open;
   logic                  beat_fire;      // Beat moves this cycle

   ////////////////////
   // Handshake gating
   assign burst_open    = (state != dma_pkg::DW_IDLE);
   assign wvalid        = burst_open && wr_data_valid;
   assign wr_data_ready = burst_open && wready;
   assign beat_fire     = wvalid && wready;

   assign w.data = wr_data;
   assign w.strb = {`DMA_STRB_W{1'b1}};                  // Full beats only
   assign w.last = (state == dma_pkg::DW_LAST);

   ////////////////////
   // Beat FSM
   always_ff @(posedge aclk) begin
      if (areset) begin
         state    <= dma_pkg::DW_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            dma_pkg::DW_IDLE: begin
               beat_cnt <= '0;
               if (burst_start) begin
                  // Single-beat burst is last from its first beat
                  state <= (burst_len == '0) ? dma_pkg::DW_LAST : dma_pkg::DW_RUN;
               end
            end

            // Count until the beat before last has moved
            dma_pkg::DW_RUN: begin
               if (beat_fire) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (beat_cnt + 1'b1 == len_q) begin
                     state <= dma_pkg::DW_LAST;
                  end
               end
            end

            dma_pkg::DW_LAST: begin
               if (beat_fire) begin
                  state <= dma_pkg::DW_IDLE;      // Burst closes next cycle
               end
            end

            default: state <= dma_pkg::DW_IDLE;
         endcase
      end
   end

   // Burst length capture
   always_ff @(posedge aclk) begin
      if (burst_start && !burst_open) begin
         len_q <= burst_len;
      end
   end

endmodule

// File: design/dma_write_master.sv
////////////////////
// AXI4 write-only DMA master
// Command controller and data sequencer joined to the client and AXI ports
////////////////////
`timescale 1ns/1ns
`include "dma_macros.svh"

module dma_write_master (
   input  logic                   aclk,
   input  logic                   areset,
   // Client command channel
   input  dma_pkg::dma_cmd_t      cmd,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   // Client data channel
   input  logic [`DMA_DATA_W-1:0] wr_data,
   input  logic                   wr_data_valid,
   output logic                   wr_data_ready,
   // Status
   output logic                   write_error,
   output dma_pkg::axi_resp_t     error_resp,
   // AXI write address channel
   output dma_pkg::axi_aw_t       aw,
   output logic                   awvalid,
   input  logic                   awready,
   // AXI write data channel
   output dma_pkg::axi_w_t        w,
   output logic                   wvalid,
   input  logic                   wready,
   // AXI write response channel
   input  logic                   bvalid,
   input  dma_pkg::axi_resp_t     bresp,
   output logic                   bready
);

   logic                  burst_start;    // Command accepted
   logic [`DMA_LEN_W-1:0] burst_len;

   ////////////////////
   // Command, address and response side
   dma_write_addr i_write_addr (
      .aclk        (aclk),
      .areset      (areset),
      .cmd         (cmd),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .aw          (aw),
      .awvalid     (awvalid),
      .awready     (awready),
      .bvalid      (bvalid),
      .bresp       (bresp),
      .bready      (bready),
      .burst_start (burst_start),
      .burst_len   (burst_len),
      .write_error (write_error),
      .error_resp  (error_resp)
   );

   ////////////////////
   // Data beat side
   dma_write_data i_write_data (
      .aclk          (aclk),
      .areset        (areset),
      .burst_start   (burst_start),
      .burst_len     (burst_len),
      .wr_data       (wr_data),
      .wr_data_valid (wr_data_valid),
      .wr_data_ready (wr_data_ready),
      .w             (w),
      .wvalid        (wvalid),
      .wready        (wready)
   );

endmodule

// File: tests/dma_write_assertions.sv
////////////////////
// Handshake assertions for the AXI4 write DMA master
// Bound into the top level by the testbench
////////////////////
`timescale 1ns/1ns

module dma_write_assertions (
   input logic             aclk,
   input logic             areset,
   input logic             cmd_ready,
   input dma_pkg::axi_aw_t aw,
   input logic             awvalid,
   input logic             awready,
   input logic             wvalid,
   input logic             wready,
   input logic             bready
);

   ////////////////////
   // AXI write channels

   // Address valid and payload hold until the slave takes them
   aw_hold: assert property (@(posedge aclk) disable iff (areset)
      awvalid && !awready |=> awvalid && $stable(aw))
      else $error("awvalid dropped or aw changed before awready");

   // Data valid holds until wready
   w_hold: assert property (@(posedge aclk) disable iff (areset)
      wvalid && !wready |=> wvalid)
      else $error("wvalid dropped before wready");

   // Response wait starts only after the address handshake
   b_after_aw: assert property (@(posedge aclk) disable iff (areset)
      !(bready && awvalid))
      else $error("bready high while awvalid still pending");

   ////////////////////
   // Client side, idle means no channel activity
   idle_quiet: assert property (@(posedge aclk) disable iff (areset)
      cmd_ready |-> !awvalid && !bready)
      else $error("cmd_ready high while a burst is in flight");

endmodule

// File: tests/tb_dma_write_master.sv
////////////////////
// Testbench for the AXI4 write DMA master
// LFSR stimulus, AXI slave model, scoreboard and timeout
////////////////////
`timescale 1ns/1ns

module tb_dma_write_master;

   localparam int unsigned TIMEOUT_CYCLES = 40 * 256 * 4 + 4000;  // Worst case plus margin
   localparam logic [15:0] SEED   = 16'd62281;
   localparam int          ERR_AW = 0;   // Address channel
   localparam int          ERR_W  = 1;   // Data channel and counts
   localparam int          ERR_HS = 2;   // Command handshake
   localparam int          ERR_ST = 3;   // Status and reset values

   logic aclk = 1'b0;
   logic areset;
   dma_pkg::dma_cmd_t  cmd;
   logic               cmd_valid, cmd_ready;
   logic [63:0]        wr_data;
   logic               wr_data_valid, wr_data_ready;
   logic               write_error;
   dma_pkg::axi_resp_t error_resp;
   dma_pkg::axi_aw_t   aw;
   logic               awvalid, awready;
   dma_pkg::axi_w_t    w;
   logic               wvalid, wready;
   logic               bvalid, bready;
   dma_pkg::axi_resp_t bresp;

   ////////////////////
   // Model state
   logic [15:0]       lfsr;
   int unsigned       cycle_cnt = 0;
   int                err_cnt [4];
   dma_pkg::dma_cmd_t aw_exp_q [$];     // Accepted commands awaiting AW
   logic [7:0]        len_q [$];        // Bursts with W beats outstanding
   logic [63:0]       feed_q [$];       // Client beats not yet moved
   logic [63:0]       w_exp_q [$];      // Expected W data in order
   int                beat_idx, cmds_left, resp_cnt, resp_wait;
   int                beats_sent, beats_seen;
   logic              busy, expect_ready, hold_valid, bad_mode;
   logic              aw_seen, last_seen, resp_armed;
   logic [1:0]        bad_code;         // Last response code sent

   always #5 aclk = ~aclk;

   dma_write_master i_dma_write_master (.*);

   bind dma_write_master dma_write_assertions i_assertions (
      .aclk(aclk), .areset(areset), .cmd_ready(cmd_ready), .aw(aw), .awvalid(awvalid),
      .awready(awready), .wvalid(wvalid), .wready(wready), .bready(bready));

   // Run limit
   always @(posedge aclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////
   // Random source
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[62:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return r;
   endfunction

   function automatic logic coin();
      logic [63:0] r;
      r = rand_bits(1);
      return r[0];
   endfunction

   ////////////////////
   // Reporting
   task automatic report_error(input int cat, input string msg);
      err_cnt[cat]++;
      $display("%s", msg);
   endtask

   task automatic compare_hex(input string sig, input logic [63:0] got,
                              input logic [63:0] exp, input int cat);
      assert (got === exp) else begin
         err_cnt[cat]++;
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", sig, got, exp);
      end
   endtask

   task automatic idle_inputs();
      cmd           = '0;
      cmd_valid     = 1'b0;
      wr_data       = '0;
      wr_data_valid = 1'b0;
      awready       = 1'b0;
      wready        = 1'b0;
      bvalid        = 1'b0;
      bresp         = 2'b00;
   endtask

   task automatic clear_model();
      aw_exp_q.delete();
      len_q.delete();
      feed_q.delete();
      w_exp_q.delete();
      beat_idx     = 0;
      cmds_left    = 0;
      busy         = 1'b0;
      expect_ready = 1'b0;
      hold_valid   = 1'b0;
      bad_mode     = 1'b0;
      aw_seen      = 1'b0;
      last_seen    = 1'b0;
      resp_armed   = 1'b0;
   endtask

   // Four reset cycles with outputs checked on the last one
   task automatic apply_reset();
      areset = 1'b1;
      idle_inputs();
      clear_model();
      repeat (4) @(posedge aclk);
      compare_hex("cmd_ready", 64'(cmd_ready), 64'h0, ERR_ST);
      compare_hex("awvalid", 64'(awvalid), 64'h0, ERR_ST);
      compare_hex("wvalid", 64'(wvalid), 64'h0, ERR_ST);
      compare_hex("wr_data_ready", 64'(wr_data_ready), 64'h0, ERR_ST);
      compare_hex("bready", 64'(bready), 64'h0, ERR_ST);
      compare_hex("write_error", 64'(write_error), 64'h0, ERR_ST);
      compare_hex("error_resp", 64'(error_resp), 64'h0, ERR_ST);
      #1;
      areset = 1'b0;
   endtask

   ////////////////////
   // Scoreboard
   task automatic accept_command();
      logic [63:0] d;
      aw_exp_q.push_back(cmd);
      len_q.push_back(cmd.len);
      for (int i = 0; i <= int'(cmd.len); i++) begin
         d = rand_bits(64);                      // Client stream for this burst
         feed_q.push_back(d);
         w_exp_q.push_back(d);
      end
      beats_sent += int'(cmd.len) + 1;
      busy = 1'b1;
      cmds_left--;
   endtask

   task automatic check_aw();
      dma_pkg::dma_cmd_t exp;
      if (aw_exp_q.size() == 0) begin
         report_error(ERR_AW, "AW handshake with no accepted command");
      end else begin
         exp = aw_exp_q.pop_front();
         compare_hex("awaddr", 64'(aw.addr), 64'(exp.addr), ERR_AW);
         compare_hex("awlen", 64'(aw.len), 64'(exp.len), ERR_AW);
         compare_hex("awsize", 64'(aw.size), 64'h3, ERR_AW);     // 8-byte beats
         compare_hex("awburst", 64'(aw.burst), 64'h1, ERR_AW);   // INCR
         compare_hex("awcache", 64'(aw.cache), 64'hF, ERR_AW);
         compare_hex("awprot", 64'(aw.prot), 64'h2, ERR_AW);     // Non-secure
         compare_hex("awlock", 64'(aw.lock), 64'h0, ERR_AW);     // Normal access
         compare_hex("awqos", 64'(aw.qos), 64'h0, ERR_AW);
      end
      aw_seen = 1'b1;
   endtask

   task automatic check_w();
      logic [63:0] d;
      if (w_exp_q.size() == 0 || len_q.size() == 0) begin
         report_error(ERR_W, "W beat with no client beat outstanding");
      end else begin
         d = w_exp_q.pop_front();
         compare_hex("wdata", w.data, d, ERR_W);
         compare_hex("wstrb", 64'(w.strb), 64'hFF, ERR_W);
         compare_hex("wlast", 64'(w.last), 64'(beat_idx == int'(len_q[0])), ERR_W);
         if (beat_idx == int'(len_q[0])) begin
            void'(len_q.pop_front());
            beat_idx  = 0;
            last_seen = 1'b1;
         end else begin
            beat_idx++;
         end
      end
      beats_seen++;
   endtask

   ////////////////////
   // Client and AXI slave drivers acting 1 ns after the edge
   task automatic drive(input logic cmd_hs, input logic wd_hs, input logic b_hs);
      logic [63:0] r;
      if (hold_valid) begin
         cmd_valid = 1'b1;                       // Keep pushing while parked
      end else if (!(cmd_valid && !cmd_hs)) begin
         cmd_valid = (cmds_left > 0) && coin();
         if (cmd_valid) begin
            r        = rand_bits(29);
            cmd.addr = {r[28:0], 3'b000};        // 8-byte aligned
            r        = coin() ? rand_bits(3) : rand_bits(8);
            cmd.len  = r[7:0];
         end
      end
      if (!(wr_data_valid && !wd_hs)) begin     // Beat holds until taken
         wr_data_valid = (feed_q.size() > 0) && coin();
         if (wr_data_valid) wr_data = feed_q[0];
      end
      awready = coin();
      wready  = coin();
      if (b_hs) begin
         bvalid     = 1'b0;
         resp_armed = 1'b0;
      end else if (resp_armed && !bvalid) begin
         if (resp_wait == 0) begin
            bvalid   = 1'b1;
            bresp    = {bad_mode, coin()};       // SLVERR/DECERR or OKAY/EXOKAY
            bad_code = bresp;
         end else begin
            resp_wait--;
         end
      end else if (!resp_armed && aw_seen && last_seen) begin
         r          = rand_bits(3);              // Response delay
         resp_wait  = int'(r[2:0]);
         resp_armed = 1'b1;
         aw_seen    = 1'b0;
         last_seen  = 1'b0;
      end
   endtask

   // One clock cycle that samples at the edge and then drives
   task automatic step();
      logic cmd_hs, aw_hs, w_hs, wd_hs, b_hs;
      @(posedge aclk);
      cmd_hs = cmd_valid && cmd_ready;
      aw_hs  = awvalid && awready;
      w_hs   = wvalid && wready;
      wd_hs  = wr_data_valid && wr_data_ready;
      b_hs   = bvalid && bready;
      assert (!(cmd_hs && busy))
         else report_error(ERR_HS, "Command accepted while a burst was in flight");
      if (busy) begin
         assert (!cmd_ready) else report_error(ERR_HS, "cmd_ready high during a burst");
      end
      if (expect_ready) begin
         assert (cmd_ready)
            else report_error(ERR_HS, "cmd_ready not back one cycle after a good response");
         expect_ready = 1'b0;
      end
      if (hold_valid) begin                      // Parked after a bad response
         compare_hex("write_error", 64'(write_error), 64'h1, ERR_ST);
         compare_hex("error_resp", 64'(error_resp), 64'(bad_code), ERR_ST);
      end
      if (cmd_hs) accept_command();
      if (aw_hs) check_aw();
      assert (w_hs == wd_hs)
         else report_error(ERR_W, "Client beat and W beat did not move together");
      if (w_hs) check_w();
      if (wd_hs && feed_q.size() > 0) void'(feed_q.pop_front());
      if (b_hs) begin
         busy         = bad_mode;                // Error keeps the master closed
         expect_ready = !bad_mode;
         resp_cnt++;
      end
      #1;
      drive(cmd_hs, wd_hs, b_hs);
   endtask

   task automatic run_commands(input int n, input logic bad);
      int target;
      target    = resp_cnt + n;
      cmds_left = n;
      bad_mode  = bad;
      while (resp_cnt < target) step();
   endtask

   ////////////////////
   // Test sequence
   initial begin
      int total;
      for (int i = 0; i < 4; i++) err_cnt[i] = 0;
      lfsr       = SEED;
      resp_cnt   = 0;
      beats_sent = 0;
      beats_seen = 0;
      bad_code   = 2'b00;
      idle_inputs();
      apply_reset();
      run_commands(40, 1'b0);                    // Good responses
      run_commands(1, 1'b1);                     // Bad response parks the master
      hold_valid = 1'b1;
      repeat (51) step();
      apply_reset();
      run_commands(1, 1'b0);                     // Fresh command after reset
      step();
      assert (beats_seen == beats_sent && w_exp_q.size() == 0 && aw_exp_q.size() == 0)
         else report_error(ERR_W, "Beat or command counts do not match at the end");
      total = err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3];
      $display("Errors: aw %0d, w %0d, handshake %0d, status %0d",
               err_cnt[ERR_AW], err_cnt[ERR_W], err_cnt[ERR_HS], err_cnt[ERR_ST]);
      if (total == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+design
design/dma_pkg.sv
design/dma_write_addr.sv
design/dma_write_data.sv
design/dma_write_master.sv
tests/dma_write_assertions.sv
tests/tb_dma_write_master.sv

// File: Makefile
# Verilator build and run for the AXI4 write DMA master

TOP = tb_dma_write_master

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
